//--- design/mem_types_pkg.sv
package mem_types_pkg;

  // the translator and aligner lane logic is written for a 32-bit word
  localparam int DATA_WIDTH = 32;
  localparam int BYTES_PER_WORD = DATA_WIDTH / 8;
  localparam int OFF_WIDTH = $clog2(BYTES_PER_WORD);

  // one memory word, big-endian byte order
  typedef logic [DATA_WIDTH-1:0] word_t;

  // byte offset inside a word, 0 selects bits 31..24
  typedef logic [OFF_WIDTH-1:0] byte_off_t;

endpackage

//--- design/lsu_ops_pkg.sv
package lsu_ops_pkg;

  // access size code
  typedef logic [1:0] size_t;

  localparam size_t SIZE_BYTE = 2'd3;
  localparam size_t SIZE_HALF = 2'd1;   // any other code is a word

  // kind of access held for the duration of a request
  typedef enum logic
  {
    OP_LOAD,
    OP_STORE
  } lsu_op_e;

  // handshake and RAM sequencing states
  typedef enum logic [1:0]
  {
    ST_IDLE,
    ST_READ,      // port a address on the bus
    ST_FINISH,    // old word valid, store written, result captured
    ST_RELEASE    // ack high, waiting for req to drop
  } lsu_state_e;

endpackage

//--- design/ram_port_if.sv
`timescale 1ns/10ps

interface ram_port_if
  import mem_types_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
) ();

  logic [ADDR_WIDTH-1:0] addr;   // word address
  word_t                 wdata;
  logic                  we;
  word_t                 rdata;  // registered, one cycle after addr

  modport ctrl
  (
    output addr,
    output wdata,
    output we,
    input  rdata
  );

  modport ram
  (
    input  addr,
    input  wdata,
    input  we,
    output rdata
  );

endinterface

//--- design/dual_port_ram.sv
`timescale 1ns/10ps

module dual_port_ram
  import mem_types_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
)
(
  input logic   clk,
  ram_port_if.ram a,
  ram_port_if.ram b
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  word_t mem [DEPTH];

  // both ports write the same array, port b wins a same-address collision
  always_ff @(posedge clk)
  begin
    if (a.we)
      mem[a.addr] <= a.wdata;
    if (b.we)
      mem[b.addr] <= b.wdata;
  end

  // registered reads return the word being written this cycle
  always_ff @(posedge clk)
  begin
    if (b.we && (b.addr == a.addr))
      a.rdata <= b.wdata;
    else if (a.we)
      a.rdata <= a.wdata;
    else
      a.rdata <= mem[a.addr];
  end

  always_ff @(posedge clk)
  begin
    if (b.we)
      b.rdata <= b.wdata;
    else if (a.we && (a.addr == b.addr))
      b.rdata <= a.wdata;
    else
      b.rdata <= mem[b.addr];
  end

endmodule

//--- design/load_data_translator.sv
`timescale 1ns/10ps

module load_data_translator
  import mem_types_pkg::*, lsu_ops_pkg::*;
(
  input  word_t     read_word,
  input  byte_off_t offset,
  input  size_t     size,
  input  logic      sign_ext,
  output word_t     result
);

  logic [7:0]  byte_lane;
  logic [15:0] half_lane;
  logic        sign_bit;

  // big-endian lanes, offset 0 is the top byte
  always_comb
  begin
    case (offset)
      2'd0:    byte_lane = read_word[31:24];
      2'd1:    byte_lane = read_word[23:16];
      2'd2:    byte_lane = read_word[15:8];
      default: byte_lane = read_word[7:0];
    endcase
  end

  // halfword only looks at address bit 1
  assign half_lane = offset[1] ? read_word[15:0] : read_word[31:16];

  always_comb
  begin
    case (size)
      SIZE_BYTE:
      begin
        sign_bit = sign_ext & byte_lane[7];
        result   = {{24{sign_bit}}, byte_lane};
      end
      SIZE_HALF:
      begin
        sign_bit = sign_ext & half_lane[15];
        result   = {{16{sign_bit}}, half_lane};
      end
      default:
      begin
        sign_bit = 1'b0;   // word needs no extension
        result   = read_word;
      end
    endcase
  end

endmodule

//--- design/store_data_aligner.sv
`timescale 1ns/10ps

module store_data_aligner
  import mem_types_pkg::*, lsu_ops_pkg::*;
(
  input  word_t     old_word,
  input  word_t     store_data,
  input  byte_off_t offset,
  input  size_t     size,
  output word_t     merged
);

  // same lane map as the load translator so a load reads back what was stored
  always_comb
  begin
    merged = old_word;
    case (size)
      SIZE_BYTE:
      begin
        case (offset)
          2'd0:    merged[31:24] = store_data[7:0];
          2'd1:    merged[23:16] = store_data[7:0];
          2'd2:    merged[15:8]  = store_data[7:0];
          default: merged[7:0]   = store_data[7:0];
        endcase
      end
      SIZE_HALF:
      begin
        if (offset[1])
          merged[15:0] = store_data[15:0];
        else
          merged[31:16] = store_data[15:0];
      end
      default:
      begin
        // full word replaces the old contents
        merged = store_data;
      end
    endcase
  end

endmodule

//--- design/lsu_ctrl.sv
`timescale 1ns/10ps

module lsu_ctrl
  import mem_types_pkg::*, lsu_ops_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
)
(
  input  logic                  clk,
  input  logic                  resetn,

  // requester side
  input  logic                  req,
  input  logic                  we,
  input  size_t                 size,
  input  logic                  sign_ext,
  input  logic [ADDR_WIDTH+1:0] addr,
  input  word_t                 wdata,
  output logic                  ack,
  output word_t                 rdata,

  // datapath side
  input  word_t                 load_result,
  input  word_t                 merged_word,
  output byte_off_t             off,
  output size_t                 lat_size,
  output logic                  lat_sign_ext,
  output word_t                 lat_wdata,

  ram_port_if.ctrl              port_a,
  ram_port_if.ctrl              port_b
);

  lsu_state_e            state;
  lsu_op_e               lat_op;
  logic [ADDR_WIDTH-1:0] lat_addr;   // word address
  logic                  accept;

  assign accept = (state == ST_IDLE) && req;

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      state <= ST_IDLE;
      ack   <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (req)
            state <= ST_READ;
        end
        ST_READ:
        begin
          state <= ST_FINISH;   // RAM registers the old word here
        end
        ST_FINISH:
        begin
          ack   <= 1'b1;
          state <= ST_RELEASE;
        end
        ST_RELEASE:
        begin
          // stay here as long as the requester holds req
          if (!req)
          begin
            ack   <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // request fields held until the next accept
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      lat_op       <= we ? OP_STORE : OP_LOAD;
      lat_addr     <= addr[ADDR_WIDTH+1:2];
      off          <= addr[1:0];
      lat_size     <= size;
      lat_sign_ext <= sign_ext;
      lat_wdata    <= wdata;
    end
  end

  // load result stays put through release
  always_ff @(posedge clk)
  begin
    if ((state == ST_FINISH) && (lat_op == OP_LOAD))
      rdata <= load_result;
  end

  // port a only ever reads
  assign port_a.addr  = lat_addr;
  assign port_a.wdata = lat_wdata;
  assign port_a.we    = 1'b0;

  // port b writes the merged word once, in finish
  assign port_b.addr  = lat_addr;
  assign port_b.wdata = merged_word;
  assign port_b.we    = (state == ST_FINISH) && (lat_op == OP_STORE);

endmodule

//--- design/lsu_top.sv
`timescale 1ns/10ps

module lsu_top
  import mem_types_pkg::*, lsu_ops_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
)
(
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  req,
  input  logic                  we,
  input  size_t                 size,
  input  logic                  sign_ext,
  input  logic [ADDR_WIDTH+1:0] addr,    // byte address
  input  word_t                 wdata,
  output logic                  ack,
  output word_t                 rdata
);

  word_t     load_result;
  word_t     merged_word;
  byte_off_t off;
  size_t     lat_size;
  logic      lat_sign_ext;
  word_t     lat_wdata;

  ram_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) port_a ();
  ram_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) port_b ();

  lsu_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) u_ctrl
  (
    .clk          (clk),
    .resetn       (resetn),
    .req          (req),
    .we           (we),
    .size         (size),
    .sign_ext     (sign_ext),
    .addr         (addr),
    .wdata        (wdata),
    .ack          (ack),
    .rdata        (rdata),
    .load_result  (load_result),
    .merged_word  (merged_word),
    .off          (off),
    .lat_size     (lat_size),
    .lat_sign_ext (lat_sign_ext),
    .lat_wdata    (lat_wdata),
    .port_a       (port_a.ctrl),
    .port_b       (port_b.ctrl)
  );

  dual_port_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_ram
  (
    .clk (clk),
    .a   (port_a.ram),
    .b   (port_b.ram)
  );

  // both lane blocks work on the word read through port a
  load_data_translator u_ld_xlat
  (
    .read_word (port_a.rdata),
    .offset    (off),
    .size      (lat_size),
    .sign_ext  (lat_sign_ext),
    .result    (load_result)
  );

  store_data_aligner u_st_align
  (
    .old_word   (port_a.rdata),
    .store_data (lat_wdata),
    .offset     (off),
    .size       (lat_size),
    .merged     (merged_word)
  );

endmodule

//--- test/lsu_assertions.sv
`timescale 1ns/10ps

module lsu_assertions
  import mem_types_pkg::*, lsu_ops_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
)
(
  input logic                  clk,
  input logic                  resetn,
  input logic                  req,
  input logic                  we,
  input size_t                 size,
  input logic                  sign_ext,
  input logic [ADDR_WIDTH+1:0] addr,
  input word_t                 wdata,
  input logic                  ack,
  input word_t                 rdata,
  input lsu_state_e            state
);

  word_t                 shadow [1 << ADDR_WIDTH];   // expected memory contents
  word_t                 exp_rdata;
  logic [ADDR_WIDTH-1:0] widx;
  byte_off_t             boff;
  int                    fail_count = 0;

  assign widx = addr[ADDR_WIDTH+1:2];
  assign boff = addr[1:0];

  // lane found by shifting, offset 0 is the top byte
  function automatic word_t load_view(input word_t w, input byte_off_t off,
                                      input size_t sz, input logic sx);
    int    sh;
    word_t lane;
    word_t fill;
    if (sz == SIZE_BYTE)
    begin
      sh   = 8 * (3 - int'(off));
      lane = (w >> sh) & 32'h0000_00ff;
      fill = (sx && lane[7]) ? 32'hffff_ff00 : '0;
    end
    else if (sz == SIZE_HALF)
    begin
      sh   = off[1] ? 0 : 16;
      lane = (w >> sh) & 32'h0000_ffff;
      fill = (sx && lane[15]) ? 32'hffff_0000 : '0;
    end
    else
    begin
      lane = w;
      fill = '0;
    end
    return lane | fill;
  endfunction

  function automatic word_t store_view(input word_t old_w, input word_t data,
                                       input byte_off_t off, input size_t sz);
    int    sh;
    word_t mask;
    if (sz == SIZE_BYTE)
    begin
      sh   = 8 * (3 - int'(off));
      mask = 32'h0000_00ff << sh;
    end
    else if (sz == SIZE_HALF)
    begin
      sh   = off[1] ? 0 : 16;
      mask = 32'h0000_ffff << sh;
    end
    else
    begin
      sh   = 0;
      mask = '1;   // whole word
    end
    return (old_w & ~mask) | ((data << sh) & mask);
  endfunction

  // request fields are still held by the requester in finish
  always @(posedge clk)
  begin
    if (resetn && (state == ST_FINISH))
    begin
      if (we)
        shadow[widx] <= store_view(shadow[widx], wdata, boff, size);
      else
        exp_rdata <= load_view(shadow[widx], boff, size, sign_ext);
    end
  end

  a_reset_ack: assert property (@(posedge clk) !resetn |=> !ack)
    else
    begin
      fail_count++;
      $error("[FAIL] %0t: ack high after a reset cycle", $time);
    end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!resetn)
    $rose(ack) |-> req)
    else
    begin
      fail_count++;
      $error("[FAIL] %0t: ack rose while req was low", $time);
    end

  a_ack_fall: assert property (@(posedge clk) disable iff (!resetn)
    $fell(ack) |-> !$past(req))
    else
    begin
      fail_count++;
      $error("[FAIL] %0t: ack fell before req was sampled low", $time);
    end

  a_ack_latency: assert property (@(posedge clk) disable iff (!resetn)
    $rose(ack) |-> $past((state == ST_IDLE) && req, 3))
    else
    begin
      fail_count++;
      $error("[FAIL] %0t: ack rose at the wrong distance from accept", $time);
    end

  a_accept_ack: assert property (@(posedge clk) disable iff (!resetn)
    $past((state == ST_IDLE) && req, 3) |-> $rose(ack))
    else
    begin
      fail_count++;
      $error("[FAIL] %0t: accepted request got no ack in time", $time);
    end

  a_load_data: assert property (@(posedge clk) disable iff (!resetn)
    ($rose(ack) && !we) |-> (rdata == exp_rdata))
    else
    begin
      fail_count++;
      $error("[FAIL] %0t: load data %h, expected %h", $time,
             $sampled(rdata), $sampled(exp_rdata));
    end

  // back-pressure must not disturb a finished load
  a_hold_stable: assert property (@(posedge clk) disable iff (!resetn)
    ((state == ST_RELEASE) && req && ack && !we) |=> (ack && $stable(rdata)))
    else
    begin
      fail_count++;
      $error("[FAIL] %0t: ack or rdata changed while req was held", $time);
    end

endmodule

// sees the control state of the top level directly
bind lsu_top lsu_assertions #(.ADDR_WIDTH(ADDR_WIDTH)) chk
(
  .clk      (clk),
  .resetn   (resetn),
  .req      (req),
  .we       (we),
  .size     (size),
  .sign_ext (sign_ext),
  .addr     (addr),
  .wdata    (wdata),
  .ack      (ack),
  .rdata    (rdata),
  .state    (u_ctrl.state)
);

//--- test/lsu_tb.sv
`timescale 1ns/10ps

module lsu_tb
  import mem_types_pkg::*, lsu_ops_pkg::*;
();

  localparam int TB_ADDR_WIDTH = 4;   // 16 words, addresses collide often
  localparam int N_FILL = 1 << TB_ADDR_WIDTH;
  localparam int N_RANDOM = 300;
  localparam int CYCLE_LIMIT = (N_FILL + N_RANDOM) * 10 + 200;

  logic                     clk;
  logic                     resetn;
  logic                     req;
  logic                     we;
  size_t                    size;
  logic                     sign_ext;
  logic [TB_ADDR_WIDTH+1:0] addr;
  word_t                    wdata;
  logic                     ack;
  word_t                    rdata;

  logic [31:0] rng;
  int          load_count;
  int          store_count;
  int          timeout_count = 0;
  int          cycle_count = 0;

  lsu_top #(.ADDR_WIDTH(TB_ADDR_WIDTH)) dut0
  (
    .clk      (clk),
    .resetn   (resetn),
    .req      (req),
    .we       (we),
    .size     (size),
    .sign_ext (sign_ext),
    .addr     (addr),
    .wdata    (wdata),
    .ack      (ack),
    .rdata    (rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] seed_in);
    return seed_in * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic finish_run();
    int total_errors;
    total_errors = dut0.chk.fail_count + timeout_count;
    $display("loads %0d, stores %0d, assertion failures %0d, timeouts %0d",
             load_count, store_count, dut0.chk.fail_count, timeout_count);
    if (total_errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  endtask

  // one four-phase handshake, outputs looked at on the falling edge
  task automatic do_access(input logic is_store, input size_t sz, input logic sx,
                           input logic [TB_ADDR_WIDTH+1:0] byte_addr,
                           input word_t data, input int hold);
    req      <= 1'b1;
    we       <= is_store;
    size     <= sz;
    sign_ext <= sx;
    addr     <= byte_addr;
    wdata    <= data;
    @(negedge clk);
    while (!ack)
      @(negedge clk);
    @(posedge clk);
    repeat (hold)
      @(posedge clk);   // unit sits in release meanwhile
    req <= 1'b0;
    @(negedge clk);
    while (ack)
      @(negedge clk);
    @(posedge clk);
    if (is_store)
      store_count++;
    else
      load_count++;
  endtask

  // watchdog
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == CYCLE_LIMIT)
    begin
      timeout_count = 1;
      $display("timeout: accesses did not complete within %0d cycles", CYCLE_LIMIT);
      finish_run();
    end
  end

  initial
  begin
    logic                     op_store;
    size_t                    op_size;
    logic                     op_sx;
    logic [TB_ADDR_WIDTH+1:0] op_addr;
    int                       op_hold;

    rng         = 32'hbc16;
    load_count  = 0;
    store_count = 0;
    resetn      = 1'b0;
    req         = 1'b0;
    we          = 1'b0;
    size        = '0;
    sign_ext    = 1'b0;
    addr        = '0;
    wdata       = '0;

    repeat (3)
      @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);

    // word stores to every address first
    for (int i = 0; i < N_FILL; i++)
    begin
      rng     = lcg_step(rng);
      op_addr = {i[TB_ADDR_WIDTH-1:0], 2'b00};
      do_access(1'b1, 2'd0, 1'b0, op_addr, rng, 0);
    end

    for (int n = 0; n < N_RANDOM; n++)
    begin
      rng      = lcg_step(rng);
      op_store = rng[31];
      op_size  = rng[29:28];   // 0 and 2 are both words
      op_sx    = rng[27];
      op_addr  = rng[TB_ADDR_WIDTH+21:20];
      op_hold  = int'(rng[17:16]);
      rng      = lcg_step(rng);
      do_access(op_store, op_size, op_sx, op_addr, rng, op_hold);
    end

    repeat (4)
      @(posedge clk);   // let the last checks settle
    finish_run();
  end

endmodule

//--- vlog.f
design/mem_types_pkg.sv
design/lsu_ops_pkg.sv
design/ram_port_if.sv
design/dual_port_ram.sv
design/load_data_translator.sv
design/store_data_aligner.sv
design/lsu_ctrl.sv
design/lsu_top.sv
test/lsu_assertions.sv
test/lsu_tb.sv

//--- Makefile
SIM := obj_dir/Vlsu_tb
SRCS := $(shell grep -v '^+' vlog.f)

.PHONY: all run clean

all: run

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module lsu_tb -f vlog.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
